// ==== rv_settings.svh ====
`ifndef RV_SETTINGS_SVH
`define RV_SETTINGS_SVH

// Data path width of the integer pipeline.
`define RV_XLEN 32

// RV32E has sixteen architectural registers.
`define RV_NUM_REGS 16

// Only the low four bits of each register field are decoded.
`define RV_REG_AW 4

`endif

// ==== rv_pkg.sv ====
`default_nettype none

package rv_pkg;

  // Major opcodes handled by the decode stage.
  typedef enum logic [6:0] {
    OP_LUI   = 7'b0110111,
    OP_AUIPC = 7'b0010111,
    OP_IMM   = 7'b0010011,
    OP_REG   = 7'b0110011
  } rv_opcode_e;

  // ALU operation, encoded as {funct7[5], funct3}.
  typedef enum logic [3:0] {
    ALU_ADD  = 4'b0000,
    ALU_SLL  = 4'b0001,
    ALU_SLT  = 4'b0010,
    ALU_SLTU = 4'b0011,
    ALU_XOR  = 4'b0100,
    ALU_SRL  = 4'b0101,
    ALU_OR   = 4'b0110,
    ALU_AND  = 4'b0111,
    ALU_SUB  = 4'b1000,
    ALU_SRA  = 4'b1101
  } rv_alu_op_e;

endpackage

`default_nettype wire

// ==== rv_regfile.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "rv_settings.svh"

module rv_regfile (
  input  wire logic                  clk,
  input  wire logic                  rst,
  input  wire logic [`RV_REG_AW-1:0] raddr1_i,
  input  wire logic [`RV_REG_AW-1:0] raddr2_i,
  output logic      [`RV_XLEN-1:0]   rdata1_o,
  output logic      [`RV_XLEN-1:0]   rdata2_o,
  input  wire logic                  we_i,
  input  wire logic [`RV_REG_AW-1:0] waddr_i,
  input  wire logic [`RV_XLEN-1:0]   wdata_i
);

  logic [`RV_XLEN-1:0] regs [1:`RV_NUM_REGS-1];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < `RV_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i && waddr_i != '0) begin
      regs[waddr_i] <= wdata_i;  // Entry zero is never written.
    end
  end

  assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
  assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];

endmodule

`default_nettype wire

// ==== rv_idu.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "rv_settings.svh"

module rv_idu
  import rv_pkg::*;
(
  input  wire logic                  clk,
  input  wire logic                  rst,
  input  wire logic                  inst_valid_i,
  input  wire logic [31:0]           inst_i,
  input  wire logic [`RV_XLEN-1:0]   pc_i,
  output logic                       inst_ready_o,
  output logic      [`RV_REG_AW-1:0] rs1_o,
  output logic      [`RV_REG_AW-1:0] rs2_o,
  input  wire logic [`RV_XLEN-1:0]   rdata1_i,
  input  wire logic [`RV_XLEN-1:0]   rdata2_i,
  input  wire logic                  exu_fwd_valid_i,
  input  wire logic [`RV_REG_AW-1:0] exu_fwd_rd_i,
  input  wire logic [`RV_XLEN-1:0]   exu_fwd_data_i,
  output logic                       valid_o,
  input  wire logic                  exu_ready_i,
  output rv_alu_op_e                 alu_op_o,
  output logic      [`RV_XLEN-1:0]   op1_o,
  output logic      [`RV_XLEN-1:0]   op2_o,
  output logic      [`RV_REG_AW-1:0] rd_o,
  output logic                       illegal_o
);

  logic                valid_q;
  logic [31:0]         inst_q;
  logic [`RV_XLEN-1:0] pc_q;
  rv_opcode_e          opcode;
  logic [2:0]          funct3;
  logic                funct7_b5;
  logic [`RV_XLEN-1:0] imm_i;
  logic [`RV_XLEN-1:0] imm_u;
  logic                fwd1;
  logic                fwd2;
  logic [`RV_XLEN-1:0] src1;
  logic [`RV_XLEN-1:0] src2;

  // Decode can take a new instruction when empty or when its current one moves on.
  assign inst_ready_o = !valid_q || exu_ready_i;
  assign valid_o      = valid_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= 1'b0;
    end else if (inst_ready_o) begin
      valid_q <= inst_valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (inst_valid_i && inst_ready_o) begin
      inst_q <= inst_i;
      pc_q   <= pc_i;
    end
  end

  assign opcode    = rv_opcode_e'(inst_q[6:0]);
  assign funct3    = inst_q[14:12];
  assign funct7_b5 = inst_q[30];
  assign rs1_o     = inst_q[15 +: `RV_REG_AW];  // Field bit 4 is ignored on RV32E.
  assign rs2_o     = inst_q[20 +: `RV_REG_AW];
  assign rd_o      = inst_q[7 +: `RV_REG_AW];

  assign imm_i = {{(`RV_XLEN-12){inst_q[31]}}, inst_q[31:20]};
  assign imm_u = {inst_q[31:12], 12'b0};

  // A result still held in execute is newer than the register file copy.
  assign fwd1 = exu_fwd_valid_i && exu_fwd_rd_i == rs1_o && rs1_o != '0;
  assign fwd2 = exu_fwd_valid_i && exu_fwd_rd_i == rs2_o && rs2_o != '0;
  assign src1 = fwd1 ? exu_fwd_data_i : rdata1_i;
  assign src2 = fwd2 ? exu_fwd_data_i : rdata2_i;

  always_comb begin
    alu_op_o  = ALU_ADD;
    op1_o     = '0;
    op2_o     = '0;
    illegal_o = 1'b0;
    case (opcode)
      OP_LUI: begin
        op2_o = imm_u;
      end
      OP_AUIPC: begin
        op1_o = pc_q;
        op2_o = imm_u;
      end
      OP_IMM: begin
        op1_o    = src1;
        op2_o    = imm_i;
        alu_op_o = rv_alu_op_e'({funct7_b5 && funct3 == 3'b101, funct3});  // Only SRAI.
      end
      OP_REG: begin
        op1_o    = src1;
        op2_o    = src2;
        // funct7 bit 5 selects SUB and SRA; elsewhere it has no meaning.
        alu_op_o = rv_alu_op_e'({funct7_b5 && (funct3 == 3'b000 || funct3 == 3'b101),
                                 funct3});
      end
      default: begin
        illegal_o = 1'b1;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== rv_exu.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "rv_settings.svh"

module rv_exu
  import rv_pkg::*;
(
  input  wire logic                  clk,
  input  wire logic                  rst,
  input  wire logic                  valid_i,
  output logic                       ready_o,
  input  wire rv_alu_op_e            alu_op_i,
  input  wire logic [`RV_XLEN-1:0]   op1_i,
  input  wire logic [`RV_XLEN-1:0]   op2_i,
  input  wire logic [`RV_REG_AW-1:0] rd_i,
  input  wire logic                  illegal_i,
  output logic                       wb_valid_o,
  input  wire logic                  wb_ready_i,
  output logic      [`RV_REG_AW-1:0] wb_rd_o,
  output logic      [`RV_XLEN-1:0]   wb_data_o,
  output logic                       wb_illegal_o,
  output logic                       fwd_valid_o
);

  logic                  valid_q;
  logic [`RV_REG_AW-1:0] rd_q;
  logic [`RV_XLEN-1:0]   data_q;
  logic                  illegal_q;
  logic [4:0]            shamt;
  logic [`RV_XLEN-1:0]   alu_res;

  assign shamt = op2_i[4:0];

  always_comb begin
    case (alu_op_i)
      ALU_ADD:  alu_res = op1_i + op2_i;
      ALU_SUB:  alu_res = op1_i - op2_i;
      ALU_SLL:  alu_res = op1_i << shamt;
      ALU_SLT:  alu_res = {{(`RV_XLEN-1){1'b0}}, $signed(op1_i) < $signed(op2_i)};
      ALU_SLTU: alu_res = {{(`RV_XLEN-1){1'b0}}, op1_i < op2_i};
      ALU_XOR:  alu_res = op1_i ^ op2_i;
      ALU_SRL:  alu_res = op1_i >> shamt;
      ALU_SRA:  alu_res = $unsigned($signed(op1_i) >>> shamt);
      ALU_OR:   alu_res = op1_i | op2_i;
      ALU_AND:  alu_res = op1_i & op2_i;
      default:  alu_res = op1_i + op2_i;
    endcase
  end

  // The result slot frees up when empty or when writeback takes it this cycle.
  assign ready_o = !valid_q || wb_ready_i;

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= 1'b0;
    end else if (ready_o) begin
      valid_q <= valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (valid_i && ready_o) begin
      data_q    <= alu_res;
      rd_q      <= rd_i;
      illegal_q <= illegal_i;
    end
  end

  assign wb_valid_o   = valid_q;
  assign wb_rd_o      = rd_q;
  assign wb_data_o    = data_q;
  assign wb_illegal_o = illegal_q;
  assign fwd_valid_o  = valid_q && !illegal_q;  // An illegal result must not be forwarded.

endmodule

`default_nettype wire

// ==== rv_pipe_top.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "rv_settings.svh"

module rv_pipe_top
  import rv_pkg::*;
(
  input  wire logic                  clk,
  input  wire logic                  rst,
  input  wire logic                  inst_valid_i,
  input  wire logic [31:0]           inst_i,
  input  wire logic [`RV_XLEN-1:0]   pc_i,
  output logic                       inst_ready_o,
  output logic                       wb_valid_o,
  input  wire logic                  wb_ready_i,
  output logic      [`RV_REG_AW-1:0] wb_rd_o,
  output logic      [`RV_XLEN-1:0]   wb_data_o,
  output logic                       wb_illegal_o
);

  logic [`RV_REG_AW-1:0] rs1;
  logic [`RV_REG_AW-1:0] rs2;
  logic [`RV_XLEN-1:0]   rdata1;
  logic [`RV_XLEN-1:0]   rdata2;
  logic                  idu_valid;
  logic                  exu_ready;
  rv_alu_op_e            idu_alu_op;
  logic [`RV_XLEN-1:0]   idu_op1;
  logic [`RV_XLEN-1:0]   idu_op2;
  logic [`RV_REG_AW-1:0] idu_rd;
  logic                  idu_illegal;
  logic                  exu_fwd_valid;
  logic                  rf_we;

  // Retire on the writeback handshake; illegal instructions leave the registers alone.
  assign rf_we = wb_valid_o && wb_ready_i && !wb_illegal_o;

  rv_idu i_rv_idu (
    .clk             (clk),
    .rst             (rst),
    .inst_valid_i    (inst_valid_i),
    .inst_i          (inst_i),
    .pc_i            (pc_i),
    .inst_ready_o    (inst_ready_o),
    .rs1_o           (rs1),
    .rs2_o           (rs2),
    .rdata1_i        (rdata1),
    .rdata2_i        (rdata2),
    .exu_fwd_valid_i (exu_fwd_valid),
    .exu_fwd_rd_i    (wb_rd_o),
    .exu_fwd_data_i  (wb_data_o),
    .valid_o         (idu_valid),
    .exu_ready_i     (exu_ready),
    .alu_op_o        (idu_alu_op),
    .op1_o           (idu_op1),
    .op2_o           (idu_op2),
    .rd_o            (idu_rd),
    .illegal_o       (idu_illegal)
  );

  rv_exu i_rv_exu (
    .clk          (clk),
    .rst          (rst),
    .valid_i      (idu_valid),
    .ready_o      (exu_ready),
    .alu_op_i     (idu_alu_op),
    .op1_i        (idu_op1),
    .op2_i        (idu_op2),
    .rd_i         (idu_rd),
    .illegal_i    (idu_illegal),
    .wb_valid_o   (wb_valid_o),
    .wb_ready_i   (wb_ready_i),
    .wb_rd_o      (wb_rd_o),
    .wb_data_o    (wb_data_o),
    .wb_illegal_o (wb_illegal_o),
    .fwd_valid_o  (exu_fwd_valid)
  );

  rv_regfile i_rv_regfile (
    .clk      (clk),
    .rst      (rst),
    .raddr1_i (rs1),
    .raddr2_i (rs2),
    .rdata1_o (rdata1),
    .rdata2_o (rdata2),
    .we_i     (rf_we),
    .waddr_i  (wb_rd_o),
    .wdata_i  (wb_data_o)
  );

endmodule

`default_nettype wire

// ==== rv_pipe_props.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "rv_settings.svh"

module rv_pipe_props (
  input wire logic                  clk,
  input wire logic                  rst,
  input wire logic                  inst_ready_o,
  input wire logic                  wb_valid_o,
  input wire logic                  wb_ready_i,
  input wire logic [`RV_REG_AW-1:0] wb_rd_o,
  input wire logic [`RV_XLEN-1:0]   wb_data_o,
  input wire logic                  wb_illegal_o
);

  // A stalled writeback keeps its whole payload until the handshake.
  a_wb_hold: assert property (@(posedge clk) disable iff (rst)
    wb_valid_o && !wb_ready_i |=> wb_valid_o && $stable(wb_rd_o) && $stable(wb_data_o)
                                  && $stable(wb_illegal_o))
    else $error("writeback payload changed while stalled");

  a_reset_empty: assert property (@(posedge clk) rst |=> !wb_valid_o)
    else $error("writeback valid in the cycle after reset");

  // With writeback ready both stages drain, so decode can always accept.
  a_accept: assert property (@(posedge clk) disable iff (rst) wb_ready_i |-> inst_ready_o)
    else $error("instruction refused while writeback is ready");

endmodule

bind rv_pipe_top rv_pipe_props i_rv_pipe_props (
  .clk          (clk),
  .rst          (rst),
  .inst_ready_o (inst_ready_o),
  .wb_valid_o   (wb_valid_o),
  .wb_ready_i   (wb_ready_i),
  .wb_rd_o      (wb_rd_o),
  .wb_data_o    (wb_data_o),
  .wb_illegal_o (wb_illegal_o)
);

`default_nettype wire

// ==== tb_rv_pipe_top.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "rv_settings.svh"

module tb_rv_pipe_top
  import rv_pkg::*;
();

  logic                  clk = 1'b0;
  logic                  rst;
  logic                  inst_valid_i;
  logic [31:0]           inst_i;
  logic [`RV_XLEN-1:0]   pc_i;
  logic                  inst_ready_o;
  logic                  wb_valid_o;
  logic                  wb_ready_i;
  logic [`RV_REG_AW-1:0] wb_rd_o;
  logic [`RV_XLEN-1:0]   wb_data_o;
  logic                  wb_illegal_o;

  logic [31:0]           tbl_inst [$];
  logic [`RV_XLEN-1:0]   tbl_pc [$];
  logic                  tbl_idle [$];
  logic                  tbl_stall [$];
  logic [`RV_XLEN-1:0]   next_pc = 32'h100;
  logic [`RV_REG_AW-1:0] exp_rd [$];
  logic [`RV_XLEN-1:0]   exp_data [$];
  logic                  exp_ill [$];
  logic [`RV_XLEN-1:0]   shadow [`RV_NUM_REGS];
  integer                seed;
  int                    cycles = 0;
  int                    limit = 0;
  int                    checks = 0;
  int                    errors = 0;

  always #5 clk = ~clk;

  rv_pipe_top i_rv_pipe_top (.*);

  function automatic logic [31:0] enc_i(input logic [2:0] f3, input logic [3:0] rd,
                                        input logic [3:0] rs1, input logic [11:0] imm);
    return {imm, 1'b0, rs1, f3, 1'b0, rd, OP_IMM};
  endfunction

  function automatic logic [31:0] enc_r(input logic alt, input logic [3:0] rs2,
                                        input logic [3:0] rs1, input logic [2:0] f3,
                                        input logic [3:0] rd);
    return {1'b0, alt, 5'b0, 1'b0, rs2, 1'b0, rs1, f3, 1'b0, rd, OP_REG};
  endfunction

  function automatic logic [31:0] enc_u(input logic [6:0] opc, input logic [3:0] rd,
                                        input logic [19:0] imm);
    return {imm, 1'b0, rd, opc};
  endfunction

  // Reference ALU selected directly by funct3 and the alternate bit.
  function automatic logic [31:0] alu_model(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
    case (f3)
      3'd0:    return alt ? a - b : a + b;
      3'd1:    return a << b[4:0];
      3'd2:    return {31'b0, $signed(a) < $signed(b)};
      3'd3:    return {31'b0, a < b};
      3'd4:    return a ^ b;
      3'd5:    return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6:    return a | b;
      default: return a & b;
    endcase
  endfunction

  task automatic apply_model(input logic [31:0] inst, input logic [31:0] pc);
    logic [3:0]  rd;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] immi;
    logic [31:0] immu;
    logic [31:0] res;
    logic        ill;
    rd   = inst[10:7];  // Field bit 4 is dropped on RV32E.
    a    = shadow[inst[18:15]];
    b    = shadow[inst[23:20]];
    immi = {{20{inst[31]}}, inst[31:20]};
    immu = {inst[31:12], 12'h000};
    ill  = 1'b0;
    res  = '0;
    case (inst[6:0])
      OP_LUI:   res = immu;
      OP_AUIPC: res = pc + immu;
      OP_IMM:   res = alu_model(inst[14:12], inst[14:12] == 3'd5 && inst[30], a, immi);
      OP_REG:   res = alu_model(inst[14:12], inst[30], a, b);
      default:  ill = 1'b1;
    endcase
    if (!ill && rd != 4'd0) begin
      shadow[rd] = res;
    end
    exp_rd.push_back(rd);
    exp_data.push_back(res);
    exp_ill.push_back(ill);
  endtask

  task automatic check_writeback();
    logic [3:0]  rd;
    logic [31:0] data;
    logic        ill;
    assert (exp_rd.size() != 0) else begin
      errors++;
      $display("Writeback at %0t has no accepted instruction behind it", $time);
    end
    if (exp_rd.size() == 0) begin
      return;
    end
    rd   = exp_rd.pop_front();
    data = exp_data.pop_front();
    ill  = exp_ill.pop_front();
    checks++;
    assert (wb_rd_o == rd) else begin
      errors++;
      $display("ERR %0t wb_rd_o expected %h got %h", $time, rd, wb_rd_o);
    end
    assert (wb_illegal_o == ill) else begin
      errors++;
      $display("ERR %0t wb_illegal_o expected %b got %b", $time, ill, wb_illegal_o);
    end
    assert (wb_data_o == data) else begin
      errors++;
      $display("ERR %0t wb_data_o expected %h got %h", $time, data, wb_data_o);
    end
  endtask

  task automatic set_ready(input logic force_low);
    wb_ready_i = force_low ? 1'b0 : (($random(seed) & 3) != 0);  // Low about one cycle in four.
  endtask

  task automatic add_row(input logic [31:0] inst, input logic idle, input logic stall);
    tbl_inst.push_back(inst);
    tbl_pc.push_back(next_pc);
    tbl_idle.push_back(idle);
    tbl_stall.push_back(stall);
    next_pc = next_pc + 32'd4;
  endtask

  task automatic build_table();
    add_row(enc_u(OP_LUI, 4'd1, 20'h80000), 1'b0, 1'b0);
    add_row(enc_i(3'd0, 4'd1, 4'd1, 12'hfff), 1'b0, 1'b0);  // Reads x1 through forwarding.
    add_row(enc_u(OP_LUI, 4'd2, 20'hfffff), 1'b0, 1'b1);
    add_row(enc_u(OP_AUIPC, 4'd3, 20'h12345), 1'b1, 1'b0);
    add_row(enc_i(3'd0, 4'd4, 4'd0, 12'hffb), 1'b0, 1'b0);
    add_row(enc_i(3'd2, 4'd5, 4'd4, 12'hffc), 1'b0, 1'b0);
    add_row(enc_i(3'd3, 4'd6, 4'd4, 12'h005), 1'b0, 1'b1);
    add_row(enc_i(3'd4, 4'd7, 4'd4, 12'h7ff), 1'b0, 1'b0);
    add_row(enc_i(3'd6, 4'd8, 4'd2, 12'h0f0), 1'b1, 1'b0);
    add_row(enc_i(3'd7, 4'd9, 4'd4, 12'h8f0), 1'b0, 1'b0);
    add_row(enc_i(3'd1, 4'd10, 4'd4, 12'h003), 1'b0, 1'b0);
    add_row(enc_i(3'd5, 4'd11, 4'd4, 12'h004), 1'b0, 1'b1);
    add_row(enc_i(3'd5, 4'd12, 4'd4, 12'h402), 1'b0, 1'b0);  // SRAI by two.
    add_row(enc_r(1'b0, 4'd2, 4'd1, 3'd0, 4'd13), 1'b0, 1'b0);
    add_row(enc_r(1'b1, 4'd1, 4'd2, 3'd0, 4'd14), 1'b0, 1'b0);
    add_row(enc_r(1'b0, 4'd5, 4'd1, 3'd1, 4'd15), 1'b0, 1'b0);
    add_row(enc_r(1'b0, 4'd1, 4'd2, 3'd2, 4'd5), 1'b0, 1'b1);
    add_row(enc_r(1'b0, 4'd2, 4'd1, 3'd3, 4'd6), 1'b0, 1'b0);
    add_row(enc_r(1'b0, 4'd3, 4'd4, 3'd4, 4'd7), 1'b0, 1'b0);
    add_row(enc_r(1'b0, 4'd12, 4'd2, 3'd5, 4'd8), 1'b0, 1'b1);
    add_row(enc_r(1'b1, 4'd5, 4'd2, 3'd5, 4'd9), 1'b0, 1'b0);
    add_row(enc_r(1'b0, 4'd9, 4'd7, 3'd7, 4'd10), 1'b0, 1'b0);
    add_row(enc_i(3'd0, 4'd1, 4'd1, 12'h001), 1'b0, 1'b0);
    add_row(enc_i(3'd0, 4'd1, 4'd1, 12'h001), 1'b1, 1'b0);
    add_row(enc_i(3'd0, 4'd0, 4'd1, 12'h005), 1'b0, 1'b0);
    add_row(enc_r(1'b0, 4'd1, 4'd0, 3'd0, 4'd3), 1'b0, 1'b0);
    add_row(32'h0000_0183, 1'b0, 1'b1);  // A load opcode is not decoded.
    add_row(enc_r(1'b0, 4'd0, 4'd3, 3'd0, 4'd5), 1'b0, 1'b0);
    add_row(32'hffff_ffff, 1'b1, 1'b0);
    add_row(enc_r(1'b0, 4'd0, 4'd15, 3'd6, 4'd6), 1'b0, 1'b0);
  endtask

  always @(posedge clk) begin
    if (!rst && wb_valid_o && wb_ready_i) begin
      check_writeback();
    end
    if (!rst && inst_valid_i && inst_ready_o) begin
      apply_model(inst_i, pc_i);
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (limit != 0 && cycles > limit) begin
      $display("Timeout after %0d cycles with writebacks still missing", cycles);
      $display(">>> FAIL");
      $finish;
    end
  end

  initial begin
    seed         = 32'hf7cc7a85;
    rst          = 1'b1;
    inst_valid_i = 1'b0;
    inst_i       = '0;
    pc_i         = '0;
    wb_ready_i   = 1'b1;
    foreach (shadow[r]) begin
      shadow[r] = '0;
    end
    build_table();
    limit = tbl_inst.size() * 4 + 20;
    repeat (3) @(posedge clk);
    #1;
    rst = 1'b0;
    for (int k = 0; k < tbl_inst.size(); k++) begin
      if (tbl_idle[k]) begin
        inst_valid_i = 1'b0;
        set_ready(1'b0);
        @(posedge clk);
        #1;
      end
      inst_valid_i = 1'b1;
      inst_i       = tbl_inst[k];
      pc_i         = tbl_pc[k];
      set_ready(tbl_stall[k]);
      @(posedge clk);
      while (!inst_ready_o) begin
        #1;
        set_ready(1'b0);
        @(posedge clk);
      end
      #1;
    end
    inst_valid_i = 1'b0;
    while (exp_rd.size() != 0) begin
      set_ready(1'b0);
      @(posedge clk);
      #1;
    end
    wb_ready_i = 1'b1;
    repeat (4) @(posedge clk);  // Any stray writeback shows up here.
    $display("checks=%0d errors=%0d", checks, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== rv_pipe_top.f ====
+incdir+.
rv_pkg.sv
rv_regfile.sv
rv_idu.sv
rv_exu.sv
rv_pipe_top.sv
rv_pipe_props.sv
tb_rv_pipe_top.sv

// ==== Makefile ====
SIM      := verilator
TOP      := tb_rv_pipe_top
FILELIST := rv_pipe_top.f
FLAGS    := --binary --timing --assert
OBJDIR   := obj_dir
LOG      := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q -x -F '>>> PASS' $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
